//--- tb.f
+incdir+include
hdl/mulPkg.sv
hdl/mulOperandStage.sv
hdl/mulRowLow.sv
hdl/mulRowHigh.sv
hdl/mulRowAdd.sv
hdl/mulUnit.sv
tests/mulUnit_asserts.sv
tests/mulUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the multiply unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
buildLog=build.log
simLog=sim.log

rm -rf "$buildDir"

verilator --binary --timing --assert -Wno-fatal \
	--top-module mulUnitTb \
	-f tb.f \
	-Mdir "$buildDir" -o mulUnitSim > "$buildLog" 2>&1
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
	cat "$buildLog"
	echo "build failed with status $buildStatus"
	exit 1
fi

"./$buildDir/mulUnitSim" > "$simLog" 2>&1
runStatus=$?
cat "$simLog"

if grep -q "test failed" "$simLog"; then
	exit 1
fi
if [ "$runStatus" -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi
if ! grep -q "test passed" "$simLog"; then
	echo "simulation log holds no pass line"
	exit 1
fi
exit 0

//--- tests/mulUnitTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_defs.svh"

module mulUnitTb;

	logic             clock;
	logic             rstN;
	mulPkg::mulReq    req;
	mulPkg::mulResult result;

	// expected output and the negedge count at which it must show
	typedef struct packed
	{
		mulPkg::mulResult expected;
		logic [31:0]      due;
	} pendingResult;

	pendingResult pendQ[$];
	logic [31:0]  cycle;
	integer       seed;
	int           productCount;
	int           waitCount;
	int           i;

	mulUnit uut
	(
		.clock  (clock),
		.rstN   (rstN),
		.req    (req),
		.result (result)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic stopWithFailure(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkResult(input string name, input mulPkg::mulResult got,
		input mulPkg::mulResult exp);
		if (got.valid !== exp.valid)
			stopWithFailure($sformatf("FAIL %s.valid got %h expected %h", name,
				got.valid, exp.valid));
		if (got.product !== exp.product)
			stopWithFailure($sformatf("FAIL %s.product got %h expected %h", name,
				got.product, exp.product));
	endtask

	task automatic checkValid(input string name, input logic got, input logic exp);
		if (got !== exp)
			stopWithFailure($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] randomWord();
		randomWord = $random(seed);
	endfunction

	function automatic mulPkg::mulOp randomOp();
		logic [31:0] pick;
		pick = randomWord();
		randomOp = mulPkg::mulOp'(pick % 3);
	endfunction

	// extend each operand to 64 bits by its signedness and keep the low 64 bits
	function automatic logic [63:0] modelProduct(input mulPkg::mulOp op,
		input logic [31:0] rs, input logic [31:0] rt);
		logic [63:0] a;
		logic [63:0] b;
		a = {32'h0, rs};
		b = {32'h0, rt};
		if (op != mulPkg::opMulU && rs[31])
			a = {32'hffffffff, rs};
		if (op == mulPkg::opMulS && rt[31])
			b = {32'hffffffff, rt};
		modelProduct = a * b;
	endfunction

	function automatic mulPkg::mulReq makeReq(input mulPkg::mulOp op,
		input logic [31:0] rs, input logic [31:0] rt);
		makeReq.valid = 1'b1;
		makeReq.op    = op;
		makeReq.rs    = rs;
		makeReq.rt    = rt;
	endfunction

	// idle cycle with garbage payload where only valid matters
	function automatic mulPkg::mulReq idleReq();
		idleReq       = makeReq(randomOp(), randomWord(), randomWord());
		idleReq.valid = 1'b0;
	endfunction

	// check what is due on a falling edge and then drive the next request
	task automatic stepCycle(input mulPkg::mulReq next, input bit track);
		pendingResult front;
		pendingResult entry;
		@(negedge clock);
		cycle = cycle + 1;
		if (pendQ.size() > 0 && pendQ[0].due == cycle)
		begin
			front = pendQ.pop_front();
			if (front.expected.valid)
			begin
				checkResult("result", result, front.expected);
				productCount++;
			end
			else
				checkValid("result.valid", result.valid, 1'b0);
		end
		else
			checkValid("result.valid", result.valid, 1'b0);
		req = next;
		if (track)
		begin
			entry.expected.valid   = next.valid;
			entry.expected.product = next.valid ? modelProduct(next.op, next.rs, next.rt) : '0;
			entry.due              = cycle + `MUL_LATENCY;
			pendQ.push_back(entry);
		end
	endtask

	task automatic issue(input mulPkg::mulOp op, input logic [31:0] rs, input logic [31:0] rt);
		stepCycle(makeReq(op, rs, rt), 1'b1);
	endtask

	initial
	begin
		seed         = 32'hcf68;
		productCount = 0;
		cycle        = 0;
		rstN         = 1'b0;
		req          = '0;

		// output valid must stay low through 5 cycles of reset
		for (i = 0; i < 5; i++)
			stepCycle(idleReq(), 1'b0);
		rstN = 1'b1;

		// first request after a few idle cycles and a wait for its result
		for (i = 0; i < 3; i++)
			stepCycle(idleReq(), 1'b1);
		issue(mulPkg::opMulS, 32'd3, 32'hfffffffb);
		waitCount = 0;
		while (result.valid !== 1'b1)
		begin
			if (waitCount >= `MUL_LATENCY + 4)
				stopWithFailure("timeout while waiting for the first valid result");
			stepCycle(idleReq(), 1'b1);
			waitCount++;
		end

		// signed corners and then random operands
		issue(mulPkg::opMulS, 32'h80000000, 32'h80000000);
		issue(mulPkg::opMulS, 32'h80000000, 32'hffffffff);
		issue(mulPkg::opMulS, 32'hffffffff, 32'hffffffff);
		issue(mulPkg::opMulS, 32'h7fffffff, 32'h80000000);
		issue(mulPkg::opMulS, 32'h80000000, 32'h00000001);
		for (i = 0; i < 40; i++)
			issue(mulPkg::opMulS, randomWord(), randomWord());

		// unsigned corners and then random operands
		issue(mulPkg::opMulU, 32'hffffffff, 32'hffffffff);
		issue(mulPkg::opMulU, 32'h80000000, 32'hffffffff);
		issue(mulPkg::opMulU, 32'h00000000, 32'hdeadbeef);
		for (i = 0; i < 40; i++)
			issue(mulPkg::opMulU, randomWord(), randomWord());

		// rt top bit set tells opMulSu apart from opMulS
		issue(mulPkg::opMulSu, 32'hffffffff, 32'h80000000);
		issue(mulPkg::opMulSu, 32'h80000000, 32'hffffffff);
		for (i = 0; i < 40; i++)
			issue(mulPkg::opMulSu, randomWord(), randomWord() | 32'h80000000);

		// random ops mixed with idle gaps
		for (i = 0; i < 200; i++)
		begin
			if (randomWord() % 5 < 3)
				issue(randomOp(), randomWord(), randomWord());
			else
				stepCycle(idleReq(), 1'b1);
		end

		// drain whatever is still in flight
		waitCount = 0;
		while (pendQ.size() > 0)
		begin
			if (waitCount >= `MUL_LATENCY + 8)
				stopWithFailure("timeout while draining the expected result queue");
			stepCycle(idleReq(), 1'b0);
			waitCount++;
		end
		for (i = 0; i < 3; i++)
			stepCycle(idleReq(), 1'b0);

		$display("checked %0d products over %0d cycles", productCount, cycle);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/mulUnit_asserts.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_defs.svh"

module mulUnitAsserts
(
	input wire logic        clock,
	input wire logic        rstN,
	input mulPkg::mulReq    req,
	input mulPkg::mulResult result,
	input mulPkg::mulRow    rowLow,
	input mulPkg::mulRow    rowHigh
);

	// result valid is the request valid seen MUL_LATENCY edges earlier
	property validLatency;
		@(posedge clock) disable iff (!rstN)
			result.valid == $past(req.valid, `MUL_LATENCY);
	endproperty

	// valid registers are cleared while reset is held
	property validLowInReset;
		@(posedge clock) !rstN |-> !result.valid;
	endproperty

	// both rows leave their second stage together
	property rowsInLockstep;
		@(posedge clock) disable iff (!rstN)
			rowLow.valid == rowHigh.valid;
	endproperty

	latencyCheck: assert property (validLatency)
		else $error("result valid does not follow request valid by the pipeline latency");

	resetCheck: assert property (validLowInReset)
		else $error("result valid high while reset is asserted");

	lockstepCheck: assert property (rowsInLockstep)
		else $error("row valids disagree at the row adder");

endmodule

// attach to every mulUnit, rows are internal nets of the top level
bind mulUnit mulUnitAsserts asserts
(
	.clock   (clock),
	.rstN    (rstN),
	.req     (req),
	.result  (result),
	.rowLow  (rowLow),
	.rowHigh (rowHigh)
);

`default_nettype wire

//--- hdl/mulUnit.sv
`timescale 1ns/1ns
`default_nettype none

module mulUnit
(
	input  wire logic        clock,
	input  wire logic        rstN,
	input  mulPkg::mulReq    req,
	output mulPkg::mulResult result
);

	// split operands, shared by both row generators
	mulPkg::mulOperands operands;

	// aligned rows, they meet in the adder on the same cycle
	mulPkg::mulRow rowLow;
	mulPkg::mulRow rowHigh;

	// edge 1, request sampled and split
	mulOperandStage operandStage
	(
		.clock    (clock),
		.rstN     (rstN),
		.req      (req),
		.operands (operands)
	);

	// edges 2 and 3, rs low half x rt
	mulRowLow rowLowGen
	(
		.clock    (clock),
		.rstN     (rstN),
		.operands (operands),
		.row      (rowLow)
	);

	// edges 2 and 3, rs high half x rt
	mulRowHigh rowHighGen
	(
		.clock    (clock),
		.rstN     (rstN),
		.operands (operands),
		.row      (rowHigh)
	);

	// edge 4, product out
	mulRowAdd rowAdd
	(
		.clock   (clock),
		.rstN    (rstN),
		.rowLow  (rowLow),
		.rowHigh (rowHigh),
		.result  (result)
	);

endmodule

`default_nettype wire

//--- hdl/mulRowAdd.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_defs.svh"

module mulRowAdd
(
	input  wire logic        clock,
	input  wire logic        rstN,
	input  mulPkg::mulRow    rowLow,
	input  mulPkg::mulRow    rowHigh,
	output mulPkg::mulResult result
);

	// output registers
	logic                       validQ;
	logic [`MUL_PROD_WIDTH-1:0] productQ;

	// final sum of the two rows
	logic [`MUL_PROD_WIDTH-1:0] rowSum;

	// both rows arrive in the same cycle
	// rowHigh.valid mirrors rowLow.valid, so only one of them drives the result
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			validQ <= 1'b0;
		end
		else
		begin
			validQ <= rowLow.valid;
		end
	end

	// carry out of bit 63 is dropped
	// the 64-bit sum is the exact product for every opcode
	assign rowSum = rowLow.row + rowHigh.row;

	always_ff @(posedge clock)
	begin
		productQ <= rowSum;
	end

	assign result.valid   = validQ;
	assign result.product = productQ;

endmodule

`default_nettype wire

//--- hdl/mulRowHigh.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_defs.svh"

module mulRowHigh
(
	input  wire logic          clock,
	input  wire logic          rstN,
	input  mulPkg::mulOperands operands,
	output mulPkg::mulRow      row
);

	// width of a 17 x 17 signed product
	localparam int prodWidth = 2 * `MUL_HALF + 2;

	// stage one, two signed partial products of aHi
	logic                          valid1Q;
	logic signed [prodWidth-1:0]   prodHiLoQ;
	logic signed [prodWidth-1:0]   prodHiHiQ;

	// stage two, aligned row
	logic                          valid2Q;
	logic [`MUL_PROD_WIDTH-1:0]    rowQ;

	// sum of aHi x extended rt, before the final shift
	logic [`MUL_PROD_WIDTH-1:0]    hiLoExt;
	logic [`MUL_PROD_WIDTH-1:0]    hiHiAligned;
	logic [`MUL_PROD_WIDTH-1:0]    hiSum;

	// valid pipe, same depth as the low row
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			valid1Q <= 1'b0;
			valid2Q <= 1'b0;
		end
		else
		begin
			valid1Q <= operands.valid;
			valid2Q <= valid1Q;
		end
	end

	// stage one
	// bLo gets a zero on top so it reads as a positive 17-bit value
	always_ff @(posedge clock)
	begin
		prodHiLoQ <= $signed(operands.aHi) * $signed({1'b0, operands.bLo});
		prodHiHiQ <= $signed(operands.aHi) * $signed(operands.bHi);
	end

	// aHi x bLo at bit 0, sign-extended
	assign hiLoExt =
		{
			{(`MUL_PROD_WIDTH - prodWidth){prodHiLoQ[prodWidth-1]}},
			prodHiLoQ
		};

	// aHi x bHi at bit 16
	assign hiHiAligned =
		{
			{(`MUL_PROD_WIDTH - prodWidth - `MUL_HALF){prodHiHiQ[prodWidth-1]}},
			prodHiHiQ,
			{`MUL_HALF{1'b0}}
		};

	// aHi x extended rt
	assign hiSum = hiLoExt + hiHiAligned;

	// stage two
	// whole row weighs 2^16 since aHi is the top half of rs
	// bits shifted out above 64 are dropped, modulo 2^64
	always_ff @(posedge clock)
	begin
		rowQ <= {hiSum[`MUL_PROD_WIDTH-`MUL_HALF-1:0], {`MUL_HALF{1'b0}}};
	end

	assign row.valid = valid2Q;
	assign row.row   = rowQ;

endmodule

`default_nettype wire

//--- hdl/mulRowLow.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_defs.svh"

module mulRowLow
(
	input  wire logic          clock,
	input  wire logic          rstN,
	input  mulPkg::mulOperands operands,
	output mulPkg::mulRow      row
);

	// width of a 17 x 17 signed product
	localparam int prodWidth = 2 * `MUL_HALF + 2;

	// stage one, two partial products of aLo
	logic                          valid1Q;
	logic [2*`MUL_HALF-1:0]        prodLoLoQ;
	logic signed [prodWidth-1:0]   prodLoHiQ;

	// stage two, aligned row
	logic                          valid2Q;
	logic [`MUL_PROD_WIDTH-1:0]    rowQ;

	// row sum ahead of the stage two register
	logic [`MUL_PROD_WIDTH-1:0]    loLoExt;
	logic [`MUL_PROD_WIDTH-1:0]    loHiAligned;
	logic [`MUL_PROD_WIDTH-1:0]    rowSum;

	// valid pipe, cleared in reset
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			valid1Q <= 1'b0;
			valid2Q <= 1'b0;
		end
		else
		begin
			valid1Q <= operands.valid;
			valid2Q <= valid1Q;
		end
	end

	// stage one
	// aLo x bLo, both unsigned, fits 32 bits
	// aLo x bHi, aLo zero-extended to 17 bits so the multiply stays signed
	always_ff @(posedge clock)
	begin
		prodLoLoQ <= operands.aLo * operands.bLo;
		prodLoHiQ <= $signed({1'b0, operands.aLo}) * $signed(operands.bHi);
	end

	// low product sits at bit 0, zero above
	assign loLoExt = {{(`MUL_PROD_WIDTH - 2*`MUL_HALF){1'b0}}, prodLoLoQ};

	// cross product sits at bit 16, sign-extended to the top
	assign loHiAligned =
		{
			{(`MUL_PROD_WIDTH - prodWidth - `MUL_HALF){prodLoHiQ[prodWidth-1]}},
			prodLoHiQ,
			{`MUL_HALF{1'b0}}
		};

	// aLo x extended rt, modulo 2^64
	assign rowSum = loLoExt + loHiAligned;

	// stage two
	always_ff @(posedge clock)
	begin
		rowQ <= rowSum;
	end

	assign row.valid = valid2Q;
	assign row.row   = rowQ;

endmodule

`default_nettype wire

//--- hdl/mulOperandStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_defs.svh"

module mulOperandStage
(
	input  wire logic           clock,
	input  wire logic           rstN,
	input  mulPkg::mulReq       req,
	output mulPkg::mulOperands  operands
);

	// registered request
	logic                  reqValidQ;
	mulPkg::mulOp          reqOpQ;
	logic [`MUL_WIDTH-1:0] rsQ;
	logic [`MUL_WIDTH-1:0] rtQ;

	// signedness decoded from the opcode
	logic rsSigned;
	logic rtSigned;

	// operands extended to 33 bits
	logic [`MUL_WIDTH:0] rsExt;
	logic [`MUL_WIDTH:0] rtExt;

	// valid is the only control bit here
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			reqValidQ <= 1'b0;
		end
		else
		begin
			reqValidQ <= req.valid;
		end
	end

	// payload, sampled every clock whether valid or not
	always_ff @(posedge clock)
	begin
		reqOpQ <= req.op;
		rsQ    <= req.rs;
		rtQ    <= req.rt;
	end

	// opcode decode, the only one in the unit
	// rs signed for opMulS and opMulSu, rt signed only for opMulS
	always_comb
	begin
		case (reqOpQ)
			mulPkg::opMulS:
			begin
				rsSigned = 1'b1;
				rtSigned = 1'b1;
			end
			mulPkg::opMulSu:
			begin
				rsSigned = 1'b1;
				rtSigned = 1'b0;
			end
			default:
			begin
				// opMulU, and the unused encoding as unsigned too
				rsSigned = 1'b0;
				rtSigned = 1'b0;
			end
		endcase
	end

	// copy the sign bit for a signed operand, zero otherwise
	assign rsExt = {rsSigned & rsQ[`MUL_WIDTH-1], rsQ};
	assign rtExt = {rtSigned & rtQ[`MUL_WIDTH-1], rtQ};

	// split into a 16-bit unsigned low half and a 17-bit signed high half
	// value of each operand is hi * 2^16 + lo
	assign operands.valid = reqValidQ;
	assign operands.aLo   = rsExt[`MUL_HALF-1:0];
	assign operands.aHi   = rsExt[`MUL_WIDTH:`MUL_HALF];
	assign operands.bLo   = rtExt[`MUL_HALF-1:0];
	assign operands.bHi   = rtExt[`MUL_WIDTH:`MUL_HALF];

endmodule

`default_nettype wire

//--- hdl/mulPkg.sv
`default_nettype none

package mulPkg;

	`include "mul_defs.svh"

	// opcode selects signedness of rs and rt
	// opMulS  : signed rs, signed rt
	// opMulU  : unsigned rs, unsigned rt
	// opMulSu : signed rs, unsigned rt
	typedef enum logic [1:0]
	{
		opMulS  = 2'd0,
		opMulU  = 2'd1,
		opMulSu = 2'd2
	} mulOp;

	// request as it arrives from the execute stage
	// valid is a level, no handshake
	typedef struct packed
	{
		logic                  valid;
		mulOp                  op;
		logic [`MUL_WIDTH-1:0] rs;
		logic [`MUL_WIDTH-1:0] rt;
	} mulReq;

	// operands after extension to 33 bits and the split into halves
	// low halves are plain unsigned
	// high halves carry the extension bit and are read as signed
	typedef struct packed
	{
		logic                 valid;
		logic [`MUL_HALF-1:0] aLo;
		logic [`MUL_HALF:0]   aHi;
		logic [`MUL_HALF-1:0] bLo;
		logic [`MUL_HALF:0]   bHi;
	} mulOperands;

	// one aligned partial sum, already at its final bit position
	typedef struct packed
	{
		logic                       valid;
		logic [`MUL_PROD_WIDTH-1:0] row;
	} mulRow;

	// unit output, full 64-bit product
	typedef struct packed
	{
		logic                       valid;
		logic [`MUL_PROD_WIDTH-1:0] product;
	} mulResult;

endpackage

`default_nettype wire

//--- include/mul_defs.svh
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// operand width of rs and rt
`define MUL_WIDTH 32

// width of one operand half
// the top half gets one extra bit for the sign or zero extension
`define MUL_HALF 16

// full product width, enough for any of the three opcodes
`define MUL_PROD_WIDTH 64

// clocks from the edge that samples a request to its valid result
// operand stage, row stage one, row stage two, row adder
`define MUL_LATENCY 4

`endif
